// ==== include/l2_cache_macros.svh ====
// widths are fixed at one word per line; a boundary below 32'h8000_0000 must stay word aligned
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

// byte address width of both buses
`define L2_ADDR_W 32

// word width, one word per cache line
`define L2_DATA_W 32

// line index bits, 16 lines
`define L2_INDEX_W 4

// first non-cacheable byte address
// everything from here up goes straight to memory
`define L2_NONCACHE_START 32'h8000_0000

`endif

// ==== src/gen_bus_pkg.sv ====
// byte lanes are little endian; byte_en bit i covers data bits 8*i+7 down to 8*i
`include "l2_cache_macros.svh"

package gen_bus_pkg;

	// byte address on the generic bus
	typedef logic [`L2_ADDR_W-1:0] addr_t;

	// one data word
	typedef logic [`L2_DATA_W-1:0] word_t;

	// one enable per byte lane
	typedef logic [`L2_DATA_W/8-1:0] byte_en_t;

	// overlay the enabled lanes of new_w onto old_w
	function automatic word_t merge_bytes(word_t old_w, word_t new_w, byte_en_t be);
		word_t result;
		result = old_w;
		for (int i = 0; i < `L2_DATA_W/8; i++) begin
			if (be[i]) begin
				result[8*i +: 8] = new_w[8*i +: 8];
			end
		end
		return result;
	endfunction

endpackage

// ==== src/l2_cache_pkg.sv ====
// direct mapped geometry only; address bits 1:0 are never stored, lines are whole words
`include "l2_cache_macros.svh"

package l2_cache_pkg;

	// byte offset inside a one-word line
	localparam int unsigned OFFSET_W = 2;
	localparam int unsigned TAG_W = `L2_ADDR_W - `L2_INDEX_W - OFFSET_W;
	localparam int unsigned NUM_LINES = 1 << `L2_INDEX_W;

	// line index, address bits 5:2
	typedef logic [`L2_INDEX_W-1:0] index_t;

	// upper address bits above the index
	typedef logic [TAG_W-1:0] tag_t;

	// controller states
	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_compare,
		st_writeback,
		st_fill,
		st_bypass,
		st_sweep,
		st_done
	} ctrl_state_t;

	// rebuild a word address from tag and index
	function automatic gen_bus_pkg::addr_t line_addr(tag_t tag, index_t index);
		return {tag, index, {OFFSET_W{1'b0}}};
	endfunction

endpackage

// ==== src/l2_cache_ifs.sv ====
// both links are point to point and unclocked; the owning modules register what they drive
`timescale 1ns/1ns

// request path from capture to controller
interface cache_req_if;
	// request side, held while req_valid is high
	logic req_valid;
	logic req_write;
	l2_cache_pkg::tag_t req_tag;
	l2_cache_pkg::index_t req_index;
	logic req_cacheable;
	gen_bus_pkg::word_t req_wdata;
	gen_bus_pkg::byte_en_t req_byte_en;

	// response side, req_done is a one cycle pulse
	logic req_done;
	gen_bus_pkg::word_t req_rdata;

	modport producer (
		output req_valid, req_write, req_tag, req_index, req_cacheable, req_wdata, req_byte_en,
		input req_done, req_rdata
	);

	modport consumer (
		input req_valid, req_write, req_tag, req_index, req_cacheable, req_wdata, req_byte_en,
		output req_done, req_rdata
	);
endinterface

// line array port between controller and store
interface line_store_if;
	// read address, data returns one cycle later
	l2_cache_pkg::index_t rd_index;
	l2_cache_pkg::tag_t rd_tag;
	logic rd_valid;
	logic rd_dirty;
	gen_bus_pkg::word_t rd_data;

	// single write port, whole line at once
	logic wr_en;
	l2_cache_pkg::index_t wr_index;
	l2_cache_pkg::tag_t wr_tag;
	gen_bus_pkg::word_t wr_data;
	logic wr_valid;
	logic wr_dirty;

	modport ctrl (
		output rd_index, wr_en, wr_index, wr_tag, wr_data, wr_valid, wr_dirty,
		input rd_tag, rd_valid, rd_dirty, rd_data
	);

	modport store (
		input rd_index, wr_en, wr_index, wr_tag, wr_data, wr_valid, wr_dirty,
		output rd_tag, rd_valid, rd_dirty, rd_data
	);
endinterface

// ==== src/l2_req_capture.sv ====
// one request at a time; address bits 1:0 are dropped, so requests are taken as word accesses
`timescale 1ns/1ns
`include "l2_cache_macros.svh"

module l2_req_capture (
	input  logic tb_CLK,
	input  logic rst,

	// processor side generic bus
	input  gen_bus_pkg::addr_t proc_addr,
	input  gen_bus_pkg::word_t proc_wdata,
	input  gen_bus_pkg::byte_en_t proc_byte_en,
	input  logic proc_ren,
	input  logic proc_wen,
	output gen_bus_pkg::word_t proc_rdata,
	output logic proc_busy,

	// toward the controller
	cache_req_if.producer req
);

	// new access seen while nothing is held
	logic take;

	assign take = !req.req_valid && (proc_ren || proc_wen);

	// request valid and processor busy
	always_ff @(posedge tb_CLK) begin
		if (rst) begin
			req.req_valid <= 1'b0;
			proc_busy <= 1'b1;
		end else begin
			// busy drops for exactly the cycle after req_done
			proc_busy <= !req.req_done;
			if (req.req_done) begin
				req.req_valid <= 1'b0;
			end else if (take) begin
				req.req_valid <= 1'b1;
			end
		end
	end

	// request payload and returned word
	always_ff @(posedge tb_CLK) begin
		if (take) begin
			// a write wins if both strobes are up
			req.req_write <= proc_wen;
			req.req_tag <= proc_addr[`L2_ADDR_W-1:`L2_INDEX_W+2];
			req.req_index <= proc_addr[`L2_INDEX_W+1:2];
			// below the boundary goes through the cache
			req.req_cacheable <= (proc_addr < `L2_NONCACHE_START);
			req.req_wdata <= proc_wdata;
			req.req_byte_en <= proc_byte_en;
		end
		// rdata only meaningful in the busy low cycle
		if (req.req_done) begin
			proc_rdata <= req.req_rdata;
		end
	end

endmodule

// ==== src/l2_line_store.sv ====
// read data lags rd_index by one cycle; a write and a read of the same index return the old line
`timescale 1ns/1ns

module l2_line_store (
	input logic tb_CLK,
	input logic rst,

	// controller port
	line_store_if.store ls
);

	// per line state bits, cleared by reset
	logic [l2_cache_pkg::NUM_LINES-1:0] valid_q;
	logic [l2_cache_pkg::NUM_LINES-1:0] dirty_q;

	// tag and word arrays
	l2_cache_pkg::tag_t tag_mem [l2_cache_pkg::NUM_LINES];
	gen_bus_pkg::word_t data_mem [l2_cache_pkg::NUM_LINES];

	// valid and dirty flags
	always_ff @(posedge tb_CLK) begin
		if (rst) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (ls.wr_en) begin
			valid_q[ls.wr_index] <= ls.wr_valid;
			dirty_q[ls.wr_index] <= ls.wr_dirty;
		end
	end

	// tag and data arrays
	// written together with the flags above
	always_ff @(posedge tb_CLK) begin
		if (ls.wr_en) begin
			tag_mem[ls.wr_index] <= ls.wr_tag;
			data_mem[ls.wr_index] <= ls.wr_data;
		end
	end

	// registered read of the flags
	// reset shows an empty line
	always_ff @(posedge tb_CLK) begin
		if (rst) begin
			ls.rd_valid <= 1'b0;
			ls.rd_dirty <= 1'b0;
		end else begin
			ls.rd_valid <= valid_q[ls.rd_index];
			ls.rd_dirty <= dirty_q[ls.rd_index];
		end
	end

	// registered read of tag and word
	always_ff @(posedge tb_CLK) begin
		ls.rd_tag <= tag_mem[ls.rd_index];
		ls.rd_data <= data_mem[ls.rd_index];
	end

endmodule

// ==== src/l2_cache_ctrl.sv ====
// flush and clear are taken only in idle with no request held; a pulse at any other time is lost
`timescale 1ns/1ns

module l2_cache_ctrl (
	input  logic tb_CLK,
	input  logic rst,

	// maintenance
	input  logic flush,
	input  logic clear,
	output logic flush_done,
	output logic clear_done,

	// memory side generic bus
	output gen_bus_pkg::addr_t mem_addr,
	output gen_bus_pkg::word_t mem_wdata,
	output gen_bus_pkg::byte_en_t mem_byte_en,
	output logic mem_ren,
	output logic mem_wen,
	input  gen_bus_pkg::word_t mem_rdata,
	input  logic mem_busy,

	// request in, line array out
	cache_req_if.consumer req,
	line_store_if.ctrl ls
);

	l2_cache_pkg::ctrl_state_t state_q, state_d;

	// sweep bookkeeping
	logic sweeping_q;
	logic sweep_flush_q;
	l2_cache_pkg::index_t sweep_idx_q;
	logic sweep_start;
	logic sweep_step;
	logic sweep_last;

	// word returned on fill or bypass
	gen_bus_pkg::word_t resp_q;
	logic resp_load;

	// line under inspection
	l2_cache_pkg::index_t cur_index;
	gen_bus_pkg::addr_t req_addr;
	logic hit;

	assign cur_index = sweeping_q ? sweep_idx_q : req.req_index;
	assign req_addr = l2_cache_pkg::line_addr(req.req_tag, req.req_index);
	assign hit = ls.rd_valid && (ls.rd_tag == req.req_tag);
	assign sweep_last = (sweep_idx_q == '1);

	// store keeps rereading the current line, so rd_* stay steady while waiting on memory
	assign ls.rd_index = cur_index;

	always_comb begin
		state_d = state_q;
		sweep_start = 1'b0;
		sweep_step = 1'b0;
		resp_load = 1'b0;
		// default write is a clean copy of the line just read
		ls.wr_en = 1'b0;
		ls.wr_index = cur_index;
		ls.wr_tag = ls.rd_tag;
		ls.wr_data = ls.rd_data;
		ls.wr_valid = 1'b1;
		ls.wr_dirty = 1'b0;
		// default memory access is a victim write-back
		mem_ren = 1'b0;
		mem_wen = 1'b0;
		mem_addr = l2_cache_pkg::line_addr(ls.rd_tag, cur_index);
		mem_wdata = ls.rd_data;
		mem_byte_en = '1;
		req.req_done = 1'b0;
		req.req_rdata = resp_q;
		flush_done = 1'b0;
		clear_done = 1'b0;
		case (state_q)
			l2_cache_pkg::st_idle: begin
				// requests first, then flush over clear
				if (req.req_valid) begin
					state_d = req.req_cacheable ? l2_cache_pkg::st_lookup :
						l2_cache_pkg::st_bypass;
				end else if (flush || clear) begin
					sweep_start = 1'b1;
					state_d = l2_cache_pkg::st_lookup;
				end
			end
			l2_cache_pkg::st_lookup: begin
				// array read in flight
				state_d = sweeping_q ? l2_cache_pkg::st_sweep : l2_cache_pkg::st_compare;
			end
			l2_cache_pkg::st_compare: begin
				if (hit) begin
					req.req_done = 1'b1;
					req.req_rdata = ls.rd_data;
					if (req.req_write) begin
						ls.wr_en = 1'b1;
						ls.wr_data = gen_bus_pkg::merge_bytes(ls.rd_data, req.req_wdata,
							req.req_byte_en);
						ls.wr_dirty = 1'b1;
					end
					state_d = l2_cache_pkg::st_idle;
				end else if (ls.rd_valid && ls.rd_dirty) begin
					state_d = l2_cache_pkg::st_writeback;
				end else begin
					state_d = l2_cache_pkg::st_fill;
				end
			end
			l2_cache_pkg::st_writeback: begin
				mem_wen = 1'b1;
				if (!mem_busy) begin
					if (sweeping_q) begin
						// flush keeps the line, now clean
						ls.wr_en = 1'b1;
						sweep_step = 1'b1;
						state_d = sweep_last ? l2_cache_pkg::st_done : l2_cache_pkg::st_lookup;
					end else begin
						state_d = l2_cache_pkg::st_fill;
					end
				end
			end
			l2_cache_pkg::st_fill: begin
				mem_ren = 1'b1;
				mem_addr = req_addr;
				if (!mem_busy) begin
					ls.wr_en = 1'b1;
					ls.wr_tag = req.req_tag;
					ls.wr_dirty = req.req_write;
					// write miss merges into the fetched word
					ls.wr_data = req.req_write ?
						gen_bus_pkg::merge_bytes(mem_rdata, req.req_wdata, req.req_byte_en) :
						mem_rdata;
					resp_load = 1'b1;
					state_d = l2_cache_pkg::st_done;
				end
			end
			l2_cache_pkg::st_bypass: begin
				// pass through with the caller's lanes
				mem_ren = !req.req_write;
				mem_wen = req.req_write;
				mem_addr = req_addr;
				mem_wdata = req.req_wdata;
				mem_byte_en = req.req_byte_en;
				if (!mem_busy) begin
					resp_load = 1'b1;
					state_d = l2_cache_pkg::st_done;
				end
			end
			l2_cache_pkg::st_sweep: begin
				if (sweep_flush_q && ls.rd_valid && ls.rd_dirty) begin
					state_d = l2_cache_pkg::st_writeback;
				end else begin
					// clear drops the line, clean flush lines are left alone
					ls.wr_en = !sweep_flush_q;
					ls.wr_valid = 1'b0;
					sweep_step = 1'b1;
					state_d = sweep_last ? l2_cache_pkg::st_done : l2_cache_pkg::st_lookup;
				end
			end
			l2_cache_pkg::st_done: begin
				if (sweeping_q) begin
					flush_done = sweep_flush_q;
					clear_done = !sweep_flush_q;
				end else begin
					req.req_done = 1'b1;
				end
				state_d = l2_cache_pkg::st_idle;
			end
			default: begin
				state_d = l2_cache_pkg::st_idle;
			end
		endcase
	end

	// state and sweep control
	always_ff @(posedge tb_CLK) begin
		if (rst) begin
			state_q <= l2_cache_pkg::st_idle;
			sweeping_q <= 1'b0;
			sweep_flush_q <= 1'b0;
			sweep_idx_q <= '0;
		end else begin
			state_q <= state_d;
			if (sweep_start) begin
				sweeping_q <= 1'b1;
				sweep_flush_q <= flush;
				sweep_idx_q <= '0;
			end else if (sweep_step) begin
				sweep_idx_q <= sweep_idx_q + 1'b1;
			end
			if (state_q == l2_cache_pkg::st_done) begin
				sweeping_q <= 1'b0;
			end
		end
	end

	// response word
	always_ff @(posedge tb_CLK) begin
		if (resp_load) begin
			resp_q <= mem_rdata;
		end
	end

endmodule

// ==== src/l2_cache.sv ====
// 16 one-word lines, write-back; flush or clear must not be raised while a request is pending
`timescale 1ns/1ns

module l2_cache (
	input  logic tb_CLK,
	input  logic rst,

	// processor side
	input  gen_bus_pkg::addr_t proc_addr,
	input  gen_bus_pkg::word_t proc_wdata,
	input  gen_bus_pkg::byte_en_t proc_byte_en,
	input  logic proc_ren,
	input  logic proc_wen,
	output gen_bus_pkg::word_t proc_rdata,
	output logic proc_busy,

	// memory side
	output gen_bus_pkg::addr_t mem_addr,
	output gen_bus_pkg::word_t mem_wdata,
	output gen_bus_pkg::byte_en_t mem_byte_en,
	output logic mem_ren,
	output logic mem_wen,
	input  gen_bus_pkg::word_t mem_rdata,
	input  logic mem_busy,

	// maintenance
	input  logic flush,
	input  logic clear,
	output logic flush_done,
	output logic clear_done
);

	// internal links
	cache_req_if req_bus ();
	line_store_if ls_bus ();

	// processor request latch
	l2_req_capture u_capture (
		.tb_CLK(tb_CLK),
		.rst(rst),
		.proc_addr(proc_addr),
		.proc_wdata(proc_wdata),
		.proc_byte_en(proc_byte_en),
		.proc_ren(proc_ren),
		.proc_wen(proc_wen),
		.proc_rdata(proc_rdata),
		.proc_busy(proc_busy),
		.req(req_bus.producer)
	);

	// tag, flag and data arrays
	l2_line_store u_store (
		.tb_CLK(tb_CLK),
		.rst(rst),
		.ls(ls_bus.store)
	);

	// hit, miss, bypass and sweep control
	l2_cache_ctrl u_ctrl (
		.tb_CLK(tb_CLK),
		.rst(rst),
		.flush(flush),
		.clear(clear),
		.flush_done(flush_done),
		.clear_done(clear_done),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_byte_en(mem_byte_en),
		.mem_ren(mem_ren),
		.mem_wen(mem_wen),
		.mem_rdata(mem_rdata),
		.mem_busy(mem_busy),
		.req(req_bus.consumer),
		.ls(ls_bus.ctrl)
	);

endmodule

// ==== test/tb_l2_cache.sv ====
// word aligned accesses only; unwritten memory reads back a pattern made from the whole address
`timescale 1ns/1ns
`include "l2_cache_macros.svh"

module tb_l2_cache;

	// one expected memory access
	typedef struct packed {
		logic write;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0] be;
	} mem_txn_t;

	localparam int TIMEOUT = 300;
	localparam int LINES = 1 << `L2_INDEX_W;

	logic tb_CLK;
	logic rst;
	logic [31:0] proc_addr;
	logic [31:0] proc_wdata;
	logic [3:0] proc_byte_en;
	logic proc_ren;
	logic proc_wen;
	logic [31:0] proc_rdata;
	logic proc_busy;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0] mem_byte_en;
	logic mem_ren;
	logic mem_wen;
	logic [31:0] mem_rdata;
	logic mem_busy;
	logic flush;
	logic clear;
	logic flush_done;
	logic clear_done;

	// memory model contents
	logic [31:0] mem [logic [31:0]];
	// reference model, memory plus one entry per line
	logic [31:0] ref_mem [logic [31:0]];
	logic [`L2_ADDR_W-`L2_INDEX_W-3:0] ref_tag [LINES];
	logic ref_valid [LINES];
	logic ref_dirty [LINES];
	logic [31:0] ref_data [LINES];
	mem_txn_t exp_txn [$];

	// separate streams so stimulus and delays never race
	logic [31:0] data_lfsr;
	logic [31:0] delay_lfsr;
	int mismatch_count;
	int failure_count;

	l2_cache u_dut (.*);

	initial begin
		tb_CLK = 1'b0;
		forever #10 tb_CLK = ~tb_CLK;
	end

	// galois lfsr, x^32+x^30+x^26+x^25+1, one step per bit
	task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], state[0]};
			state = state[0] ? ((state >> 1) ^ 32'hA300_0000) : (state >> 1);
		end
	endtask

	function automatic logic [31:0] fill_word(logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
	endfunction

	function automatic logic [31:0] ref_read(logic [31:0] addr);
		return ref_mem.exists(addr) ? ref_mem[addr] : fill_word(addr);
	endfunction

	// enabled lanes come from new_w
	function automatic logic [31:0] merge(logic [31:0] old_w, logic [31:0] new_w, logic [3:0] be);
		logic [31:0] mask;
		mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
		assert (got === want) else begin
			mismatch_count++;
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic report_failure(string what);
		failure_count++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	// memory side responder, checks each access against the queue
	task automatic complete_access();
		mem_txn_t want;
		logic [31:0] old_w;
		old_w = mem.exists(mem_addr) ? mem[mem_addr] : fill_word(mem_addr);
		if (mem_wen) begin
			mem[mem_addr] = merge(old_w, mem_wdata, mem_byte_en);
		end else begin
			mem_rdata = old_w;
		end
		if (exp_txn.size() == 0) begin
			report_failure($sformatf("unexpected memory %s at address %h",
				mem_wen ? "write" : "read", mem_addr));
		end else begin
			want = exp_txn.pop_front();
			check_value("mem_wen", {31'b0, mem_wen}, {31'b0, want.write});
			check_value("mem_addr", mem_addr, want.addr);
			check_value("mem_byte_en", {28'b0, mem_byte_en}, {28'b0, want.be});
			if (mem_wen) begin
				check_value("mem_wdata", mem_wdata, want.data);
			end
		end
	endtask

	initial begin : mem_model
		logic [31:0] pick;
		int delay_left;
		delay_lfsr = 32'h8cce;
		mem_busy = 1'b1;
		mem_rdata = '0;
		delay_left = -1;
		forever begin
			@(negedge tb_CLK);
			if (!mem_busy) begin
				// access ended, back to busy
				mem_busy = 1'b1;
			end else if (!rst && (mem_ren || mem_wen)) begin
				if (delay_left < 0) begin
					take_bits(delay_lfsr, 2, pick);
					delay_left = pick;
				end
				if (delay_left == 0) begin
					complete_access();
					delay_left = -1;
					mem_busy = 1'b0;
				end else begin
					delay_left--;
				end
			end
		end
	end

	// expected traffic and read result of one access
	task automatic predict_access(input logic write, input logic [31:0] addr,
		input logic [31:0] wdata, input logic [3:0] be,
		output logic [31:0] rdata, output logic is_hit);
		logic [`L2_INDEX_W-1:0] idx;
		logic [`L2_ADDR_W-`L2_INDEX_W-3:0] tag;
		logic [31:0] victim;
		idx = addr[`L2_INDEX_W+1:2];
		tag = addr[`L2_ADDR_W-1:`L2_INDEX_W+2];
		is_hit = 1'b0;
		rdata = ref_read(addr);
		if (addr >= `L2_NONCACHE_START) begin
			// straight through, lines untouched
			exp_txn.push_back(mem_txn_t'{write, addr, wdata, be});
			if (write) begin
				ref_mem[addr] = merge(rdata, wdata, be);
			end
		end else if (ref_valid[idx] && ref_tag[idx] == tag) begin
			is_hit = 1'b1;
			rdata = ref_data[idx];
			if (write) begin
				ref_data[idx] = merge(ref_data[idx], wdata, be);
				ref_dirty[idx] = 1'b1;
			end
		end else begin
			// dirty victim goes out before the fill
			if (ref_valid[idx] && ref_dirty[idx]) begin
				victim = {ref_tag[idx], idx, 2'b00};
				exp_txn.push_back(mem_txn_t'{1'b1, victim, ref_data[idx], 4'hf});
				ref_mem[victim] = ref_data[idx];
			end
			exp_txn.push_back(mem_txn_t'{1'b0, addr, 32'h0, 4'hf});
			ref_tag[idx] = tag;
			ref_valid[idx] = 1'b1;
			ref_dirty[idx] = write;
			ref_data[idx] = write ? merge(rdata, wdata, be) : rdata;
		end
	endtask

	// called on a falling edge, returns on the falling edge of the busy low cycle
	task automatic run_access(logic write, logic [31:0] addr, logic [31:0] wdata, logic [3:0] be);
		logic [31:0] want;
		logic is_hit;
		int cycles;
		predict_access(write, addr, wdata, be, want, is_hit);
		proc_addr = addr;
		proc_wdata = wdata;
		proc_byte_en = be;
		proc_ren = !write;
		proc_wen = write;
		cycles = 0;
		do begin
			@(negedge tb_CLK);
			cycles++;
		end while (proc_busy && cycles < TIMEOUT);
		proc_ren = 1'b0;
		proc_wen = 1'b0;
		if (proc_busy) begin
			report_failure($sformatf("timeout waiting for proc_busy low at address %h", addr));
		end else begin
			if (!write) begin
				check_value("proc_rdata", proc_rdata, want);
			end
			// hit ends on the third edge after the sampling edge
			if (is_hit) begin
				check_value("hit latency", cycles, 4);
			end
		end
		if (exp_txn.size() != 0) begin
			report_failure($sformatf("%0d expected memory accesses never seen", exp_txn.size()));
			exp_txn.delete();
		end
	endtask

	task automatic run_sweep(logic do_flush);
		int cycles;
		for (int i = 0; i < LINES; i++) begin
			if (do_flush && ref_valid[i] && ref_dirty[i]) begin
				exp_txn.push_back(mem_txn_t'{1'b1, {ref_tag[i], i[3:0], 2'b00}, ref_data[i], 4'hf});
				ref_mem[{ref_tag[i], i[3:0], 2'b00}] = ref_data[i];
				ref_dirty[i] = 1'b0;
			end else if (!do_flush) begin
				ref_valid[i] = 1'b0;
				ref_dirty[i] = 1'b0;
			end
		end
		flush = do_flush;
		clear = !do_flush;
		@(negedge tb_CLK);
		flush = 1'b0;
		clear = 1'b0;
		cycles = 0;
		while (!(do_flush ? flush_done : clear_done) && cycles < TIMEOUT) begin
			@(negedge tb_CLK);
			cycles++;
		end
		if (!(do_flush ? flush_done : clear_done)) begin
			if (do_flush) begin
				report_failure("timeout waiting for flush_done");
			end else begin
				report_failure("timeout waiting for clear_done");
			end
		end
		if (exp_txn.size() != 0) begin
			report_failure($sformatf("%0d sweep write-backs never seen", exp_txn.size()));
			exp_txn.delete();
		end
	endtask

	// memory model against reference memory
	task automatic compare_memory();
		foreach (ref_mem[a]) begin
			if (!mem.exists(a)) begin
				report_failure($sformatf("memory word %h was never written", a));
			end else begin
				check_value($sformatf("memory word %h", a), mem[a], ref_mem[a]);
			end
		end
		foreach (mem[a]) begin
			if (!ref_mem.exists(a)) begin
				report_failure($sformatf("memory word %h written but not expected", a));
			end
		end
	endtask

	busy_pulse: assert property (@(posedge tb_CLK) disable iff (rst) !proc_busy |=> proc_busy)
		else begin
			failure_count++;
			$display("error at %0t ns: proc_busy low for more than one cycle", $time);
		end

	done_pulse: assert property (@(posedge tb_CLK) disable iff (rst)
		(flush_done || clear_done) |=> !(flush_done || clear_done))
		else begin
			failure_count++;
			$display("error at %0t ns: sweep done held longer than one cycle", $time);
		end

	one_strobe: assert property (@(posedge tb_CLK) disable iff (rst)
		!(mem_ren && mem_wen) && !(flush_done && clear_done))
		else begin
			failure_count++;
			$display("error at %0t ns: conflicting strobes high together", $time);
		end

	// request held steady while memory is busy
	mem_hold: assert property (@(posedge tb_CLK) disable iff (rst)
		((mem_ren || mem_wen) && mem_busy) |=>
		((mem_ren || mem_wen) && $stable(mem_addr) && $stable(mem_wdata) &&
		$stable(mem_byte_en)))
		else begin
			failure_count++;
			$display("error at %0t ns: memory request changed while busy", $time);
		end

	initial begin : stimulus
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] be;
		logic [31:0] addr;
		data_lfsr = 32'h8cce;
		mismatch_count = 0;
		failure_count = 0;
		rst = 1'b1;
		proc_addr = '0;
		proc_wdata = '0;
		proc_byte_en = '0;
		proc_ren = 1'b0;
		proc_wen = 1'b0;
		flush = 1'b0;
		clear = 1'b0;
		for (int i = 0; i < LINES; i++) begin
			ref_valid[i] = 1'b0;
			ref_dirty[i] = 1'b0;
			ref_tag[i] = '0;
			ref_data[i] = '0;
		end
		repeat (5) @(negedge tb_CLK);
		// idle controls out of reset
		check_value("proc_busy", {31'b0, proc_busy}, 32'd1);
		check_value("mem_ren", {31'b0, mem_ren}, 32'd0);
		check_value("mem_wen", {31'b0, mem_wen}, 32'd0);
		check_value("flush_done", {31'b0, flush_done}, 32'd0);
		check_value("clear_done", {31'b0, clear_done}, 32'd0);
		rst = 1'b0;
		@(negedge tb_CLK);

		// read miss then hit
		run_access(1'b0, 32'h0000_1040, '0, 4'hf);
		run_access(1'b0, 32'h0000_1040, '0, 4'hf);
		// partial write hit, merged read
		take_bits(data_lfsr, 32, d);
		run_access(1'b1, 32'h0000_1040, d, 4'b0101);
		run_access(1'b0, 32'h0000_1040, '0, 4'hf);
		// same index, other tag, dirty victim out
		take_bits(data_lfsr, 32, d);
		run_access(1'b1, 32'h0000_1080, d, 4'hf);
		run_access(1'b0, 32'h0000_1040, '0, 4'hf);

		// random mix over four tags
		for (int n = 0; n < 48; n++) begin
			take_bits(data_lfsr, 7, r);
			take_bits(data_lfsr, 32, d);
			take_bits(data_lfsr, 4, be);
			addr = 32'h0000_2000 + {r[5:4], r[3:0], 2'b00};
			run_access(r[6], addr, d, be[3:0]);
		end

		// line 0 dirty so the flush has a write-back there
		take_bits(data_lfsr, 32, d);
		run_access(1'b1, 32'h0000_2000, d, 4'hf);
		// flush, then a conflicting miss needs no write-back
		run_sweep(1'b1);
		compare_memory();
		// flushed line still valid
		run_access(1'b0, 32'h0000_2000, '0, 4'hf);
		run_access(1'b0, 32'h0000_3000, '0, 4'hf);

		// clear discards dirty data, stale word comes back
		take_bits(data_lfsr, 32, d);
		run_access(1'b1, 32'h0000_1044, d, 4'hf);
		run_sweep(1'b0);
		run_access(1'b0, 32'h0000_1044, '0, 4'hf);

		// bypass, each access issued twice
		for (int n = 0; n < 8; n++) begin
			take_bits(data_lfsr, 9, r);
			take_bits(data_lfsr, 32, d);
			take_bits(data_lfsr, 4, be);
			addr = `L2_NONCACHE_START | {22'b0, r[7:0], 2'b00};
			run_access(r[8], addr, d, be[3:0]);
			run_access(r[8], addr, d, be[3:0]);
		end
		// cached line still a hit
		run_access(1'b0, 32'h0000_1044, '0, 4'hf);

		$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== l2_cache.f ====
+incdir+include
src/gen_bus_pkg.sv
src/l2_cache_pkg.sv
src/l2_cache_ifs.sv
src/l2_req_capture.sv
src/l2_line_store.sv
src/l2_cache_ctrl.sv
src/l2_cache.sv
test/tb_l2_cache.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS := --binary --timing --assert -Wno-fatal
TOP := tb_l2_cache
FILELIST := l2_cache.f

BUILD_DIR := obj_dir
SIM_BIN := $(BUILD_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
